// File: rtl/alu.sv
module alu import cpu_pkg::*; (
   input  logic [data_width-1:0] a,
   input  logic [data_width-1:0] b,
   input  alu_cmd_t              cmd,
   output logic [data_width-1:0] result,
   output logic                  zero
);

   logic [data_width-1:0] b_in;
   logic [data_width:0]   carry;
   logic [data_width-1:0] sum;
   logic                  overflow;
   logic                  less;

   // Every command except add runs the chain as a minus b, so slt
   // gets the difference for free
   assign b_in     = (cmd == cmd_add) ? b : ~b;
   assign carry[0] = (cmd != cmd_add);

   // Ripple chain of full-adder stages
   for (genvar i = 0; i < data_width; i++) begin : g_fa
      assign sum[i]     = a[i] ^ b_in[i] ^ carry[i];
      assign carry[i+1] = (a[i] & b_in[i]) | ((a[i] ^ b_in[i]) & carry[i]);
   end

   // Signed overflow shows up as a mismatch of the last two carries
   assign overflow = carry[data_width] ^ carry[data_width-1];

   // A sign bit that overflow has flipped still tells which operand is smaller
   assign less = sum[data_width-1] ^ overflow;

   always_comb begin
      case (cmd)
         cmd_add,
         cmd_sub:  result = sum;
         cmd_xor:  result = a ^ b;
         cmd_slt:  result = {data_width{less}};
         cmd_and:  result = a & b;
         cmd_nand: result = ~(a & b);
         cmd_nor:  result = ~(a | b);
         default:  result = a | b;
      endcase
   end

   assign zero = ~|result;

endmodule

// File: rtl/core_ctrl.sv
module core_ctrl import cpu_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     start,
   mem_bus_if.master                bus,
   output logic                     retire_valid,
   output logic [reg_idx_width-1:0] retire_rd,
   output logic [data_width-1:0]    retire_data,
   output logic                     halted
);

   enum logic [2:0] {
      st_idle,
      st_fetch,
      st_fetch_wait,
      st_execute,
      st_mem,
      st_mem_wait,
      st_writeback,
      st_halt
   } state;

   logic [addr_width-1:0]    pc;
   instr_u                   ir;
   logic [data_width-1:0]    res_q;
   logic [data_width-1:0]    st_data_q;
   logic [reg_idx_width-1:0] rt_sel;
   logic [data_width-1:0]    rs_data;
   logic [data_width-1:0]    rt_data;
   logic [data_width-1:0]    imm_ext;
   logic [data_width-1:0]    alu_b;
   alu_cmd_t                 alu_cmd;
   logic [data_width-1:0]    alu_result;
   logic                     alu_zero;

   // The immediate form has no rt field, so sw and beq take their second
   // source register from rd
   assign rt_sel  = (ir.r_fmt.opcode == op_alu_r) ? ir.r_fmt.rt : ir.i_fmt.rd;
   assign imm_ext = {{(data_width-16){ir.i_fmt.imm[15]}}, ir.i_fmt.imm};

   always_comb begin
      case (ir.r_fmt.opcode)
         op_alu_r: begin
            alu_cmd = alu_cmd_t'(ir.r_fmt.cmd[2:0]);
            alu_b   = rt_data;
         end
         op_alu_i: begin
            alu_cmd = alu_cmd_t'(ir.i_fmt.cmd[2:0]);
            alu_b   = imm_ext;
         end
         op_beq: begin
            alu_cmd = cmd_sub;
            alu_b   = rt_data;
         end
         // Load and store addresses are rs plus the immediate
         default: begin
            alu_cmd = cmd_add;
            alu_b   = imm_ext;
         end
      endcase
   end

   alu u_alu (
      .a      (rs_data),
      .b      (alu_b),
      .cmd    (alu_cmd),
      .result (alu_result),
      .zero   (alu_zero)
   );

   reg_file u_reg_file (
      .clk     (clk),
      .arst_n  (arst_n),
      .rs_idx  (ir.r_fmt.rs),
      .rt_idx  (rt_sel),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .we      (state == st_writeback),
      .wr_idx  (ir.r_fmt.rd),
      .wr_data (res_q)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
         pc    <= '0;
      end else begin
         case (state)
            st_idle,
            st_halt: begin
               if (start) begin
                  pc    <= '0;
                  state <= st_fetch;
               end
            end
            // pc moves on at the fetch grant, so a branch adds to the next pc
            st_fetch: begin
               if (bus.gnt) begin
                  pc    <= pc + 1'b1;
                  state <= st_fetch_wait;
               end
            end
            st_fetch_wait: state <= st_execute;
            st_execute: begin
               case (ir.r_fmt.opcode)
                  op_alu_r,
                  op_alu_i: state <= st_writeback;
                  op_lw,
                  op_sw:    state <= st_mem;
                  op_beq: begin
                     if (alu_zero) begin
                        pc <= pc + ir.i_fmt.imm[addr_width-1:0];
                     end
                     state <= st_fetch;
                  end
                  op_halt:  state <= st_halt;
                  default:  state <= st_fetch;
               endcase
            end
            st_mem: begin
               if (bus.gnt) begin
                  state <= (ir.r_fmt.opcode == op_lw) ? st_mem_wait : st_fetch;
               end
            end
            st_mem_wait:  state <= st_writeback;
            st_writeback: state <= st_fetch;
            default:      state <= st_idle;
         endcase
      end
   end

   // Instruction and data holding registers
   always_ff @(posedge clk) begin
      if (state == st_fetch_wait) begin
         ir <= bus.rdata;
      end
      if (state == st_execute) begin
         res_q     <= alu_result;
         st_data_q <= rt_data;
      end
      if (state == st_mem_wait) begin
         res_q <= bus.rdata;
      end
   end

   // All request fields come from registers, so they hold while stalled
   assign bus.req   = (state == st_fetch) || (state == st_mem);
   assign bus.we    = (state == st_mem) && (ir.r_fmt.opcode == op_sw);
   assign bus.addr  = (state == st_fetch) ? pc : res_q[addr_width-1:0];
   assign bus.wdata = st_data_q;

   assign retire_valid = (state == st_writeback);
   assign retire_rd    = ir.r_fmt.rd;
   assign retire_data  = res_q;
   assign halted       = (state == st_halt);

   // Without a start the core stays off the bus once idle or halted
   a_quiet_when_stopped: assert property (
      @(posedge clk) disable iff (!arst_n)
      (state inside {st_idle, st_halt}) && !start |=> !bus.req
   ) else $error("core requested memory while idle or halted");

   a_req_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      bus.req && !bus.gnt |=>
         bus.req && $stable(bus.we) && $stable(bus.addr) && (!bus.we || $stable(bus.wdata))
   ) else $error("core request changed before grant");

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

   // Machine word, memory depth and register file size
   localparam int data_width    = 32;
   localparam int addr_width    = 8;
   localparam int reg_count     = 16;
   localparam int reg_idx_width = $clog2(reg_count);

   // Three-bit ALU command encoding
   typedef enum logic [2:0] {
      cmd_add  = 3'd0,
      cmd_sub  = 3'd1,
      cmd_xor  = 3'd2,
      cmd_slt  = 3'd3,
      cmd_and  = 3'd4,
      cmd_nand = 3'd5,
      cmd_nor  = 3'd6,
      cmd_or   = 3'd7
   } alu_cmd_t;

   typedef enum logic [3:0] {
      op_alu_r = 4'd0,
      op_alu_i = 4'd1,
      op_lw    = 4'd2,
      op_sw    = 4'd3,
      op_beq   = 4'd4,
      op_halt  = 4'd5
   } opcode_t;

   // One instruction word, read either as register form or immediate form.
   // Opcode, rd, rs and the command field sit at the same place in both views
   typedef union packed {
      struct packed {
         opcode_t     opcode;
         logic [3:0]  rd;
         logic [3:0]  rs;
         logic [3:0]  cmd;
         logic [3:0]  rt;
         logic [11:0] unused;
      } r_fmt;
      struct packed {
         opcode_t     opcode;
         logic [3:0]  rd;
         logic [3:0]  rs;
         logic [3:0]  cmd;
         logic [15:0] imm;
      } i_fmt;
   } instr_u;

endpackage

// File: rtl/cpu_top.sv
module cpu_top import cpu_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     host_req,
   input  logic                     host_we,
   input  logic [addr_width-1:0]    host_addr,
   input  logic [data_width-1:0]    host_wdata,
   output logic                     host_gnt,
   output logic [data_width-1:0]    host_rdata,
   input  logic                     start,
   output logic                     retire_valid,
   output logic [reg_idx_width-1:0] retire_rd,
   output logic [data_width-1:0]    retire_data,
   output logic                     halted
);

   logic                  ram_we;
   logic [addr_width-1:0] ram_addr;
   logic [data_width-1:0] ram_wdata;
   logic [data_width-1:0] ram_rdata;

   mem_bus_if host_bus ();
   mem_bus_if core_bus ();

   // Host pins onto the host-side bus
   assign host_bus.req   = host_req;
   assign host_bus.we    = host_we;
   assign host_bus.addr  = host_addr;
   assign host_bus.wdata = host_wdata;
   assign host_gnt       = host_bus.gnt;
   assign host_rdata     = host_bus.rdata;

   mem_arbiter u_arbiter (
      .clk       (clk),
      .arst_n    (arst_n),
      .host      (host_bus.arbiter),
      .core      (core_bus.arbiter),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   word_ram u_ram (
      .clk   (clk),
      .we    (ram_we),
      .addr  (ram_addr),
      .wdata (ram_wdata),
      .rdata (ram_rdata)
   );

   core_ctrl u_core (
      .clk          (clk),
      .arst_n       (arst_n),
      .start        (start),
      .bus          (core_bus.master),
      .retire_valid (retire_valid),
      .retire_rd    (retire_rd),
      .retire_data  (retire_data),
      .halted       (halted)
   );

endmodule

// File: rtl/mem_arbiter.sv
module mem_arbiter import cpu_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   mem_bus_if.arbiter            host,
   mem_bus_if.arbiter            core,
   output logic                  ram_we,
   output logic [addr_width-1:0] ram_addr,
   output logic [data_width-1:0] ram_wdata,
   input  logic [data_width-1:0] ram_rdata
);

   logic host_rd_q;
   logic core_rd_q;

   // Host always wins; the core only gets a free cycle
   assign host.gnt = host.req;
   assign core.gnt = core.req & ~host.req;

   always_comb begin
      if (host.req) begin
         ram_we    = host.we;
         ram_addr  = host.addr;
         ram_wdata = host.wdata;
      end else begin
         ram_we    = core.gnt & core.we;
         ram_addr  = core.addr;
         ram_wdata = core.wdata;
      end
   end

   // Remember who owns the read data coming out of the RAM next cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         host_rd_q <= 1'b0;
         core_rd_q <= 1'b0;
      end else begin
         host_rd_q <= host.gnt & ~host.we;
         core_rd_q <= core.gnt & ~core.we;
      end
   end

   assign host.rdata = host_rd_q ? ram_rdata : '0;
   assign core.rdata = core_rd_q ? ram_rdata : '0;

   // Read data reaches only the master whose read was granted a cycle before
   a_core_rdata: assert property (
      @(posedge clk) disable iff (!arst_n)
      core.gnt && !core.we |=> (core.rdata == ram_rdata) && (host.rdata == '0)
   ) else $error("core read data not returned on the cycle after its grant");

endmodule

// File: rtl/mem_bus_if.sv
interface mem_bus_if import cpu_pkg::*; ();

   // Request side, held steady by the master until gnt is seen
   logic                  req;
   logic                  we;
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] wdata;

   // Grant is combinational; rdata follows a read grant by one cycle
   logic                  gnt;
   logic [data_width-1:0] rdata;

   modport master (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface

// File: rtl/reg_file.sv
module reg_file import cpu_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [reg_idx_width-1:0] rs_idx,
   input  logic [reg_idx_width-1:0] rt_idx,
   output logic [data_width-1:0]    rs_data,
   output logic [data_width-1:0]    rt_data,
   input  logic                     we,
   input  logic [reg_idx_width-1:0] wr_idx,
   input  logic [data_width-1:0]    wr_data
);

   logic [data_width-1:0] regs [reg_count];

   // Register 0 is an ordinary register here, not hardwired to zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Asynchronous read ports
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

// File: rtl/word_ram.sv
module word_ram import cpu_pkg::*; (
   input  logic                  clk,
   input  logic                  we,
   input  logic [addr_width-1:0] addr,
   input  logic [data_width-1:0] wdata,
   output logic [data_width-1:0] rdata
);

   logic [data_width-1:0] mem [2**addr_width];

   // Read data is registered, so it appears one cycle after the access.
   // A write cycle returns the old contents of the word
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

// File: testbench/cpu_checker.sv
module cpu_checker import cpu_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     host_we,
   input  logic [addr_width-1:0]    host_addr,
   input  logic [data_width-1:0]    host_wdata,
   input  logic                     host_gnt,
   input  logic [data_width-1:0]    host_rdata,
   input  logic                     retire_valid,
   input  logic [reg_idx_width-1:0] retire_rd,
   input  logic [data_width-1:0]    retire_data,
   input  logic                     halted,
   output int                       retire_errors,
   output int                       mem_errors,
   output int                       other_errors
);

   // Reference image of the words whose contents the host knows
   logic [data_width-1:0]    model [2**addr_width];
   logic                     known [2**addr_width];
   logic [reg_idx_width-1:0] exp_rd [$];
   logic [data_width-1:0]    exp_data [$];
   logic                     rd_pending = 1'b0;
   logic [addr_width-1:0]    rd_addr;
   logic                     saw_halt = 1'b0;
   int                       n_retire = 0;
   int                       n_mem = 0;
   int                       n_other = 0;

   assign retire_errors = n_retire;
   assign mem_errors    = n_mem;
   assign other_errors  = n_other;

   initial begin
      for (int i = 0; i < 2**addr_width; i++) begin
         known[i] = 1'b0;
      end
   end

   function automatic int mismatch(input string name, input logic [data_width-1:0] expected,
                                   input logic [data_width-1:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
         return 1;
      end
      return 0;
   endfunction

   task automatic expect_retire(input logic [reg_idx_width-1:0] rd,
                                input logic [data_width-1:0] data);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
   endtask

   task automatic expect_word(input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data);
      model[addr] = data;
      known[addr] = 1'b1;
   endtask

   task automatic report_missing();
      if (exp_rd.size() != 0) begin
         $display("%0t: %0d expected register writes never retired", $time, exp_rd.size());
         n_retire++;
      end
   endtask

   always @(posedge clk) begin
      if (!arst_n) begin
         n_other += mismatch("retire_valid", '0, retire_valid);
         n_other += mismatch("halted", '0, halted);
         n_other += mismatch("host_gnt", '0, host_gnt);
         rd_pending = 1'b0;
      end else begin
         // Read data belongs to the grant one cycle earlier
         if (rd_pending) begin
            if (known[rd_addr]) begin
               n_mem += mismatch("host_rdata", model[rd_addr], host_rdata);
            end else begin
               $display("%0t: host read of address %h with unknown contents", $time, rd_addr);
               n_other++;
            end
         end
         rd_pending = host_gnt && !host_we;
         rd_addr    = host_addr;
         if (host_gnt && host_we) begin
            model[host_addr] = host_wdata;
            known[host_addr] = 1'b1;
         end

         if (retire_valid) begin
            if (saw_halt) begin
               $display("%0t: register write retired after the core halted", $time);
               n_other++;
            end
            if (exp_rd.size() == 0) begin
               $display("%0t: surplus register write to r%0d", $time, retire_rd);
               n_retire++;
            end else begin
               n_retire += mismatch("retire_rd", exp_rd.pop_front(), retire_rd);
               n_retire += mismatch("retire_data", exp_data.pop_front(), retire_data);
            end
         end

         if (saw_halt && !halted) begin
            $display("%0t: halted dropped without a start pulse", $time);
            n_other++;
         end
         if (halted) begin
            saw_halt = 1'b1;
         end
      end
   end

endmodule

// File: testbench/cpu_stim.txt
// Header: program record count, retire record count, readback record count
// Each line below it holds two records of two words each
001c 0013 0004
// Program: address, word (constants at 40 and 41 are loaded by the first lw pair)
00 21000040 01 22000041
02 1300fff0 03 04102000
04 05213000 05 06223000
06 07132000 07 08231000
08 09243000 09 0a253000
0a 0b263000 0b 0c172000
0c 1d20ff00 0d 1e340f0f
0e 1f33fff8 0f 4f700001
10 11000bad 11 49800001
12 1a000055 13 34000050
14 36000051 15 3ea0fffd
16 21000050 17 22a0fffc
18 23000052 19 50000000
40 80000010 41 12345678
// Retire order: destination register, written value
1 80000010 2 12345678
3 fffffff0 4 92345688
5 12345688 6 edcba988
7 ffffffff 8 00000000
9 12345670 a edcba98f
b 00000007 c 92345678
d 12345578 e 00000f00
f ffffffff a 00000055
1 92345688 2 edcba988
3 00000f00
// Readback after halt: address, word
50 92345688 51 edcba988
52 00000f00 40 80000010

// File: testbench/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

   localparam int    stim_depth = 256;
   localparam string stim_file  = "testbench/cpu_stim.txt";

   logic                     clk;
   logic                     arst_n;
   logic                     host_req;
   logic                     host_we;
   logic [addr_width-1:0]    host_addr;
   logic [data_width-1:0]    host_wdata;
   logic                     host_gnt;
   logic [data_width-1:0]    host_rdata;
   logic                     start;
   logic                     retire_valid;
   logic [reg_idx_width-1:0] retire_rd;
   logic [data_width-1:0]    retire_data;
   logic                     halted;

   logic [31:0] stim [stim_depth];
   int          n_prog;
   int          n_retire;
   int          n_mem;
   int          cycle_limit;
   int          cycles = 0;
   int          retire_errors;
   int          mem_errors;
   int          other_errors;
   integer      seed;

   cpu_top UUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .host_req     (host_req),
      .host_we      (host_we),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_gnt     (host_gnt),
      .host_rdata   (host_rdata),
      .start        (start),
      .retire_valid (retire_valid),
      .retire_rd    (retire_rd),
      .retire_data  (retire_data),
      .halted       (halted)
   );

   cpu_checker u_checker (
      .clk           (clk),
      .arst_n        (arst_n),
      .host_we       (host_we),
      .host_addr     (host_addr),
      .host_wdata    (host_wdata),
      .host_gnt      (host_gnt),
      .host_rdata    (host_rdata),
      .retire_valid  (retire_valid),
      .retire_rd     (retire_rd),
      .retire_data   (retire_data),
      .halted        (halted),
      .retire_errors (retire_errors),
      .mem_errors    (mem_errors),
      .other_errors  (other_errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // The watchdog limit scales with program size and readback count
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         if (!halted) begin
            $display("Timeout after %0d cycles: the core never halted", cycles);
         end else begin
            $display("Timeout after %0d cycles during memory readback", cycles);
         end
         $display("Test failed");
         $finish;
      end
   end

   // One host access, held until the grant is seen at a rising edge
   task automatic host_access(input logic we, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data);
      host_req   = 1'b1;
      host_we    = we;
      host_addr  = addr;
      host_wdata = data;
      do @(posedge clk); while (!host_gnt);
      @(negedge clk);
      host_req = 1'b0;
      host_we  = 1'b0;
   endtask

   initial begin
      int idx;
      seed       = 32'h701a;
      arst_n     = 1'b0;
      host_req   = 1'b0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      start      = 1'b0;
      $readmemh(stim_file, stim);
      n_prog      = stim[0];
      n_retire    = stim[1];
      n_mem       = stim[2];
      cycle_limit = 64 * n_prog + 16 * n_mem;
      if (n_prog == 0) begin
         $display("Stim file %s could not be read or holds no program", stim_file);
         $display("Test failed");
         $finish;
      end
      for (int i = 0; i < n_retire; i++) begin
         idx = 3 + 2 * (n_prog + i);
         u_checker.expect_retire(stim[idx][reg_idx_width-1:0], stim[idx+1]);
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      for (int i = 0; i < n_prog; i++) begin
         host_access(1'b1, stim[3+2*i][addr_width-1:0], stim[4+2*i]);
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;

      // Random host reads of program words compete with the running core
      while (!halted) begin
         if ({$random(seed)} % 3 == 0) begin
            host_req  = 1'b1;
            host_we   = 1'b0;
            host_addr = stim[3 + 2 * ({$random(seed)} % n_prog)][addr_width-1:0];
         end else begin
            host_req = 1'b0;
         end
         @(negedge clk);
      end
      host_req = 1'b0;

      for (int i = 0; i < n_mem; i++) begin
         idx = 3 + 2 * (n_prog + n_retire + i);
         u_checker.expect_word(stim[idx][addr_width-1:0], stim[idx+1]);
         host_access(1'b0, stim[idx][addr_width-1:0], '0);
      end
      repeat (2) @(negedge clk);
      u_checker.report_missing();

      $display("Errors: retire %0d, memory %0d, other %0d",
               retire_errors, mem_errors, other_errors);
      if (retire_errors + mem_errors + other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/core_ctrl.sv
rtl/mem_arbiter.sv
rtl/word_ram.sv
rtl/cpu_top.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv
